/* hw/dwc_pkg.sv */
`default_nettype none

package dwc_pkg;

  // Wide requester side and narrow memory side data widths
  localparam int wide_dw = 64;
  localparam int narrow_dw = 16;

  // Narrow beats per wide beat
  localparam int ratio = wide_dw / narrow_dw;
  // Lane index width inside one wide beat
  localparam int lane_w = $clog2(ratio);

  // Byte address aligned to 8 bytes on the wide side
  localparam int aw = 16;

  // Length fields hold beats minus one
  localparam int wide_len_w = 4;
  localparam int narrow_len_w = wide_len_w + lane_w;
  // Remaining narrow beats need one more bit for the full count of 64
  localparam int narrow_cnt_w = narrow_len_w + 1;

  // Command opcode of one bit on both command ports
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } dwc_op_e;

  // Controller phases
  typedef enum logic [2:0] {
    idle       = 3'd0,
    issue      = 3'd1,
    write_data = 3'd2,
    write_resp = 3'd3,
    read_data  = 3'd4
  } dwc_state_e;

endpackage

`default_nettype wire

/* hw/dwc_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module dwc_ctrl_fsm import dwc_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  // Wide command handshake
  input  logic s_cmd_valid,
  output logic s_cmd_ready,
  input  logic s_cmd_op,
  // Narrow command handshake
  output logic m_cmd_valid,
  input  logic m_cmd_ready,
  // Write response from the narrow side to the wide side
  input  logic m_bvalid,
  output logic m_bready,
  output logic s_bvalid,
  input  logic s_bready,
  // End of burst indications
  input  logic burst_last,
  input  logic wide_last,
  // Data path enables and counter load
  output logic wr_active,
  output logic rd_active,
  output logic cnt_load
);

  dwc_state_e state_q;
  dwc_state_e state_d;
  // Opcode of the command in flight
  dwc_op_e    op_q;

  // Only one command at a time, so accept only when idle
  assign s_cmd_ready = (state_q == idle);
  assign cnt_load    = s_cmd_valid & s_cmd_ready;

  // Narrow command is offered for the whole issue phase
  assign m_cmd_valid = (state_q == issue);

  // Data paths only move in their own phase
  assign wr_active = (state_q == write_data);
  assign rd_active = (state_q == read_data);

  // Write response passes straight through in write_resp
  assign s_bvalid = (state_q == write_resp) & m_bvalid;
  assign m_bready = (state_q == write_resp) & s_bready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (cnt_load) begin
          state_d = issue;
        end
      end
      issue: begin
        // Branch on the latched opcode once the narrow side takes the command
        if (m_cmd_ready) begin
          if (op_q == op_write) begin
            state_d = write_data;
          end else begin
            state_d = read_data;
          end
        end
      end
      write_data: begin
        // Counter flags that every narrow write beat has left
        if (burst_last) begin
          state_d = write_resp;
        end
      end
      write_resp: begin
        if (m_bvalid && s_bready) begin
          state_d = idle;
        end
      end
      read_data: begin
        // Final packed beat accepted by the requester
        if (wide_last) begin
          state_d = idle;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Opcode capture on command accept
  always_ff @(posedge clk) begin
    if (cnt_load) begin
      op_q <= dwc_op_e'(s_cmd_op);
    end
  end

endmodule

`default_nettype wire

/* hw/dwc_beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module dwc_beat_counter import dwc_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  // Load strobe from the FSM on command accept
  input  logic                    cnt_load,
  input  logic [wide_len_w-1:0]   s_cmd_len,
  // One pulse per narrow transfer of the active data path
  input  logic                    narrow_step,
  // High once every narrow beat of the burst has transferred
  output logic                    burst_last,
  output logic [narrow_len_w-1:0] m_cmd_len
);

  // Latched wide length, beats minus one
  logic [wide_len_w-1:0]   len_q;
  // Narrow beats still to transfer
  logic [narrow_cnt_w-1:0] left_q;
  logic [narrow_len_w-1:0] narrow_len;

  // (len + 1) * ratio - 1 is the wide length with all lane bits set
  assign narrow_len = {s_cmd_len, {lane_w{1'b1}}};
  assign m_cmd_len  = {len_q, {lane_w{1'b1}}};

  // Nothing left means the final narrow beat has gone
  assign burst_last = (left_q == '0);

  always_ff @(posedge clk) begin
    if (cnt_load) begin
      len_q <= s_cmd_len;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      left_q <= '0;
    end else if (cnt_load) begin
      // Beat count is the length field plus one
      left_q <= narrow_cnt_w'(narrow_len) + narrow_cnt_w'(1);
    end else if (narrow_step && !burst_last) begin
      left_q <= left_q - narrow_cnt_w'(1);
    end
  end

endmodule

`default_nettype wire

/* hw/dwc_wdata_split.sv */
`timescale 1ns/1ps
`default_nettype none

module dwc_wdata_split import dwc_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // FSM is in the write data phase
  input  logic                 wr_active,
  // Wide write data from the requester
  input  logic                 s_wdata_valid,
  output logic                 s_wdata_ready,
  input  logic [wide_dw-1:0]   s_wdata,
  // Narrow write data toward memory
  output logic                 m_wdata_valid,
  input  logic                 m_wdata_ready,
  output logic [narrow_dw-1:0] m_wdata,
  // Narrow transfer strobe for the beat counter
  output logic                 narrow_step
);

  // Held wide beat
  logic [wide_dw-1:0] buf_q;
  logic               full_q;
  // Lane currently offered starting from the low lane
  logic [lane_w-1:0]  lane_q;
  logic               lane_end;
  logic               wide_take;

  assign m_wdata_valid = full_q;
  assign m_wdata       = buf_q[lane_q*narrow_dw +: narrow_dw];
  assign narrow_step   = m_wdata_valid & m_wdata_ready;

  // Top lane leaving frees the register
  assign lane_end = narrow_step & (lane_q == lane_w'(ratio - 1));

  // Refill when empty, or back to back with the final lane
  assign s_wdata_ready = wr_active & (~full_q | lane_end);
  assign wide_take     = s_wdata_valid & s_wdata_ready;

  always_ff @(posedge clk) begin
    if (wide_take) begin
      buf_q <= s_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      lane_q <= '0;
    end else begin
      if (narrow_step) begin
        // Wraps to lane 0 after the top lane
        lane_q <= lane_q + lane_w'(1);
      end
      if (wide_take) begin
        full_q <= 1'b1;
      end else if (lane_end) begin
        full_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dwc_rdata_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module dwc_rdata_pack import dwc_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // FSM is in the read data phase
  input  logic                 rd_active,
  // Every narrow beat of the burst has arrived
  input  logic                 burst_last,
  // Narrow read data from memory
  input  logic                 m_rdata_valid,
  output logic                 m_rdata_ready,
  input  logic [narrow_dw-1:0] m_rdata,
  // Wide read data to the requester
  output logic                 s_rdata_valid,
  input  logic                 s_rdata_ready,
  output logic [wide_dw-1:0]   s_rdata,
  output logic                 s_rdata_last,
  // Narrow transfer strobe and final wide transfer
  output logic                 narrow_step,
  output logic                 wide_last
);

  // Wide beat under assembly
  logic [wide_dw-1:0] buf_q;
  // Lane the next narrow beat fills
  logic [lane_w-1:0]  lane_q;
  // All lanes filled and the wide beat on offer
  logic               full_q;

  // Narrow side stalls while a packed beat waits
  assign m_rdata_ready = rd_active & ~full_q;
  assign narrow_step   = m_rdata_valid & m_rdata_ready;

  assign s_rdata_valid = full_q;
  assign s_rdata       = buf_q;
  // Counter cannot move while full, so this stays stable during the offer
  assign s_rdata_last  = full_q & burst_last;
  assign wide_last     = s_rdata_valid & s_rdata_ready & s_rdata_last;

  always_ff @(posedge clk) begin
    if (narrow_step) begin
      buf_q[lane_q*narrow_dw +: narrow_dw] <= m_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_q <= '0;
      full_q <= 1'b0;
    end else begin
      if (narrow_step) begin
        lane_q <= lane_q + lane_w'(1);
        // Top lane completes the wide beat
        if (lane_q == lane_w'(ratio - 1)) begin
          full_q <= 1'b1;
        end
      end
      if (s_rdata_valid && s_rdata_ready) begin
        full_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/dwc_downsizer.sv */
`timescale 1ns/1ps
`default_nettype none

module dwc_downsizer import dwc_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  // Wide command
  input  logic                    s_cmd_valid,
  output logic                    s_cmd_ready,
  input  logic                    s_cmd_op,
  input  logic [aw-1:0]           s_cmd_addr,
  input  logic [wide_len_w-1:0]   s_cmd_len,
  // Wide write data
  input  logic                    s_wdata_valid,
  output logic                    s_wdata_ready,
  input  logic [wide_dw-1:0]      s_wdata,
  // Wide read data
  output logic                    s_rdata_valid,
  input  logic                    s_rdata_ready,
  output logic [wide_dw-1:0]      s_rdata,
  output logic                    s_rdata_last,
  // Wide write response
  output logic                    s_bvalid,
  input  logic                    s_bready,
  // Narrow command
  output logic                    m_cmd_valid,
  input  logic                    m_cmd_ready,
  output logic                    m_cmd_op,
  output logic [aw-1:0]           m_cmd_addr,
  output logic [narrow_len_w-1:0] m_cmd_len,
  // Narrow write data
  output logic                    m_wdata_valid,
  input  logic                    m_wdata_ready,
  output logic [narrow_dw-1:0]    m_wdata,
  // Narrow read data
  input  logic                    m_rdata_valid,
  output logic                    m_rdata_ready,
  input  logic [narrow_dw-1:0]    m_rdata,
  // Narrow write response
  input  logic                    m_bvalid,
  output logic                    m_bready
);

  logic cnt_load;
  logic wr_active;
  logic rd_active;
  logic burst_last;
  logic wide_last;
  logic wr_step;
  logic rd_step;
  logic narrow_step;

  // Address and opcode captured on accept by the counter load strobe
  always_ff @(posedge clk) begin
    if (cnt_load) begin
      m_cmd_addr <= s_cmd_addr;
      m_cmd_op   <= s_cmd_op;
    end
  end

  // Only one data path runs per command
  assign narrow_step = wr_active ? wr_step : rd_step;

  dwc_ctrl_fsm i_ctrl (
    .clk, .rst_n, .s_cmd_valid, .s_cmd_ready, .s_cmd_op,
    .m_cmd_valid, .m_cmd_ready, .m_bvalid, .m_bready, .s_bvalid, .s_bready,
    .burst_last, .wide_last, .wr_active, .rd_active, .cnt_load
  );

  dwc_beat_counter i_cnt (
    .clk, .rst_n, .cnt_load, .s_cmd_len, .narrow_step, .burst_last, .m_cmd_len
  );

  dwc_wdata_split i_split (
    .clk, .rst_n, .wr_active, .s_wdata_valid, .s_wdata_ready, .s_wdata,
    .m_wdata_valid, .m_wdata_ready, .m_wdata, .narrow_step(wr_step)
  );

  dwc_rdata_pack i_pack (
    .clk, .rst_n, .rd_active, .burst_last, .m_rdata_valid, .m_rdata_ready, .m_rdata,
    .s_rdata_valid, .s_rdata_ready, .s_rdata, .s_rdata_last,
    .narrow_step(rd_step), .wide_last
  );

endmodule

`default_nettype wire

/* bench/dwc_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dwc_mem_model import dwc_pkg::*; #(
  parameter int seed_init = 55156
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    m_cmd_valid,
  output logic                    m_cmd_ready,
  input  logic                    m_cmd_op,
  input  logic [aw-1:0]           m_cmd_addr,
  input  logic [narrow_len_w-1:0] m_cmd_len,
  input  logic                    m_wdata_valid,
  output logic                    m_wdata_ready,
  input  logic [narrow_dw-1:0]    m_wdata,
  output logic                    m_rdata_valid,
  input  logic                    m_rdata_ready,
  output logic [narrow_dw-1:0]    m_rdata,
  output logic                    m_bvalid,
  input  logic                    m_bready
);

  // One 16-bit word per two bytes
  logic [narrow_dw-1:0] mem [2**(aw-1)];
  integer seed = seed_init;
  int base;
  int beats;
  int beat;
  logic moved;

  initial begin
    m_cmd_ready   = 1'b0;
    m_wdata_ready = 1'b0;
    m_rdata_valid = 1'b0;
    m_rdata       = '0;
    m_bvalid      = 1'b0;
    // Fill keyed on the full word address
    for (int i = 0; i < 2**(aw-1); i++) begin
      mem[i] = 16'(i * 3) ^ 16'h5aa5;
    end
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      if (m_cmd_valid && m_cmd_ready) begin
        base  = m_cmd_addr >> 1;
        beats = m_cmd_len + 1;
        beat  = 0;
        #1;
        m_cmd_ready = 1'b0;
        if (m_cmd_op == op_write) begin
          while (beat < beats) begin
            @(posedge clk);
            if (m_wdata_valid && m_wdata_ready) begin
              mem[base + beat] = m_wdata;
              beat++;
            end
            #1;
            m_wdata_ready = (beat < beats) && (($random(seed) & 3) != 0);
          end
          // Single completion after the last beat is stored
          m_bvalid = 1'b1;
          do @(posedge clk); while (!m_bready);
          #1;
          m_bvalid = 1'b0;
        end else begin
          while (beat < beats) begin
            @(posedge clk);
            moved = m_rdata_valid && m_rdata_ready;
            if (moved) begin
              beat++;
            end
            #1;
            // Valid and data hold until the beat transfers
            if (moved || !m_rdata_valid) begin
              m_rdata_valid = (beat < beats) && (($random(seed) & 3) != 0);
              m_rdata       = mem[base + beat];
            end
          end
        end
      end else begin
        #1;
        m_cmd_ready = ($random(seed) & 3) != 0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_dwc_downsize.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dwc_downsize import dwc_pkg::*; ();

  // Commands over the whole run
  localparam int n_cmds = 44;
  // Up to 16 wide beats of 4 lanes at 20 cycles each per command
  localparam int watchdog_cycles = n_cmds * 16 * ratio * 20;

  logic clk = 1'b0;
  logic rst_n;
  logic s_cmd_valid, s_cmd_ready, s_cmd_op;
  logic [aw-1:0] s_cmd_addr;
  logic [wide_len_w-1:0] s_cmd_len;
  logic s_wdata_valid, s_wdata_ready;
  logic [wide_dw-1:0] s_wdata;
  logic s_rdata_valid, s_rdata_ready, s_rdata_last;
  logic [wide_dw-1:0] s_rdata;
  logic s_bvalid, s_bready;
  logic m_cmd_valid, m_cmd_ready, m_cmd_op;
  logic [aw-1:0] m_cmd_addr;
  logic [narrow_len_w-1:0] m_cmd_len;
  logic m_wdata_valid, m_wdata_ready, m_rdata_valid, m_rdata_ready;
  logic [narrow_dw-1:0] m_wdata, m_rdata;
  logic m_bvalid, m_bready;

  // Expected memory with one 16-bit word per two bytes
  logic [narrow_dw-1:0] shadow [2**(aw-1)];
  integer seed = 55156;
  string test_name;
  int errors = 0;
  int err_mark = 0;
  int checks = 0;
  int tests = 0;
  int b_count = 0;
  // Read burst being compared and the command in flight
  int rd_word;
  int rd_len;
  int rd_beat;
  int cur_len;
  dwc_op_e cur_op;
  logic [aw-1:0] cur_addr;
  logic [wide_dw-1:0] exp_beat;

  always #2 clk = ~clk;

  dwc_downsizer i_dut (.*);
  dwc_mem_model i_mem (.*);

  // Four consecutive words with the low lane in the low bits
  function automatic logic [wide_dw-1:0] expected_wide_beat(input int word);
    logic [wide_dw-1:0] beat;
    for (int k = 0; k < ratio; k++) begin
      beat[k*narrow_dw +: narrow_dw] = shadow[word + k];
    end
    return beat;
  endfunction

  task automatic value_error(input string what, input logic [wide_dw-1:0] exp,
                             input logic [wide_dw-1:0] act);
    $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic close_test();
    tests++;
    $display("test %s done, %0d errors", test_name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic send_cmd(input dwc_op_e op, input logic [aw-1:0] addr, input int len);
    cur_len     = len;
    cur_op      = op;
    cur_addr    = addr;
    s_cmd_valid = 1'b1;
    s_cmd_op    = op;
    s_cmd_addr  = addr;
    s_cmd_len   = wide_len_w'(len);
    do @(posedge clk); while (!s_cmd_ready);
    #1;
    s_cmd_valid = 1'b0;
  endtask

  task automatic write_burst(input logic [aw-1:0] addr, input int len);
    logic [wide_dw-1:0] data;
    int b_start;
    b_start = b_count;
    send_cmd(op_write, addr, len);
    for (int beat = 0; beat <= len; beat++) begin
      data          = {$random(seed), $random(seed)};
      s_wdata_valid = 1'b1;
      s_wdata       = data;
      do @(posedge clk); while (!s_wdata_ready);
      #1;
      // Lane 0 lands at the lowest word
      for (int k = 0; k < ratio; k++) begin
        shadow[addr / 2 + beat * ratio + k] = data[k*narrow_dw +: narrow_dw];
      end
    end
    s_wdata_valid = 1'b0;
    do @(posedge clk); while (!(s_bvalid && s_bready));
    #1;
    checks++;
    if (b_count != b_start + 1) begin
      value_error("write responses", 1, b_count - b_start);
    end
  endtask

  task automatic read_burst(input logic [aw-1:0] addr, input int len);
    int b_start;
    b_start = b_count;
    rd_word = addr / 2;
    rd_len  = len;
    rd_beat = 0;
    send_cmd(op_read, addr, len);
    while (rd_beat <= rd_len) begin
      @(posedge clk);
      #1;
    end
    checks++;
    if (b_count != b_start) begin
      value_error("read responses", 0, b_count - b_start);
    end
  endtask

  // Completions seen by the requester
  always @(posedge clk) begin
    if (rst_n && s_bvalid && s_bready) begin
      b_count++;
    end
  end

  // Every wide read beat against the shadow memory
  always @(posedge clk) begin
    if (rst_n && s_rdata_valid && s_rdata_ready) begin
      exp_beat = expected_wide_beat(rd_word + rd_beat * ratio);
      checks++;
      if (s_rdata !== exp_beat) begin
        value_error("rdata", exp_beat, s_rdata);
      end
      if (s_rdata_last !== (rd_beat == rd_len)) begin
        value_error("rdata_last", rd_beat == rd_len, s_rdata_last);
      end
      rd_beat++;
    end
  end

  // Narrow command carries the wide opcode and address and ratio times the wide beats
  always @(posedge clk) begin
    if (rst_n && m_cmd_valid && m_cmd_ready) begin
      checks++;
      if (m_cmd_len !== narrow_len_w'((cur_len + 1) * ratio - 1)) begin
        value_error("m_cmd_len", (cur_len + 1) * ratio - 1, m_cmd_len);
      end
      if (m_cmd_op !== cur_op) begin
        value_error("m_cmd_op", cur_op, m_cmd_op);
      end
      if (m_cmd_addr !== cur_addr) begin
        value_error("m_cmd_addr", cur_addr, m_cmd_addr);
      end
    end
  end

  // Requester back-pressure
  always @(posedge clk) begin
    #1;
    s_rdata_ready = ($random(seed) & 3) != 0;
    s_bready      = ($random(seed) & 1) != 0;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [aw-1:0] addr;
    int len;
    rst_n         = 1'b0;
    s_cmd_valid   = 1'b0;
    s_cmd_op      = 1'b0;
    s_cmd_addr    = '0;
    s_cmd_len     = '0;
    s_wdata_valid = 1'b0;
    s_wdata       = '0;
    s_rdata_ready = 1'b0;
    s_bready      = 1'b0;
    for (int i = 0; i < 2**(aw-1); i++) begin
      shadow[i] = 16'(i * 3) ^ 16'h5aa5;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_name = "reset";
    checks++;
    // Ready high and every valid toward either side low
    if ({s_cmd_ready, m_cmd_valid, m_wdata_valid, s_rdata_valid, s_bvalid} !== 5'b10000) begin
      value_error("ready/valid", 5'b10000,
                  {s_cmd_ready, m_cmd_valid, m_wdata_valid, s_rdata_valid, s_bvalid});
    end
    close_test();
    test_name = "single";
    write_burst(16'h0040, 0);
    read_burst(16'h0040, 0);
    close_test();
    test_name = "burst16";
    write_burst(16'h0200, 15);
    read_burst(16'h0200, 15);
    close_test();
    test_name = "random";
    repeat (40) begin
      // Small aligned window so reads overlap earlier writes
      addr = 16'(({$random(seed)} % 64) * 8);
      len  = {$random(seed)} % 16;
      if ($random(seed) & 1) begin
        write_burst(addr, len);
      end else begin
        read_burst(addr, len);
      end
    end
    close_test();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/dwc_pkg.sv
hw/dwc_ctrl_fsm.sv
hw/dwc_beat_counter.sv
hw/dwc_wdata_split.sv
hw/dwc_rdata_pack.sv
hw/dwc_downsizer.sv
bench/dwc_mem_model.sv
bench/tb_dwc_downsize.sv
